/* design/usbPacketPkg.sv */
package usbPacketPkg;

    // ==================================================================
    // PIDs and packet classes
    // ==================================================================

    // Full PID byte with its check nibble
    typedef enum logic [7:0] {
        pidOut   = 8'hE1,
        pidIn    = 8'h69,
        pidSetup = 8'h2D,
        pidData0 = 8'hC3,
        pidData1 = 8'h4B,
        pidAck   = 8'hD2,
        pidNak   = 8'h5A,
        pidStall = 8'h1E
    } UsbPid;

    // Coarse class taken from the PID
    typedef enum logic [1:0] {
        kindToken = 2'd0,
        kindData  = 2'd1,
        kindOther = 2'd2
    } PacketKind;

    // Token bytes 1 and 2 after the PID
    // Byte 1 sits in the low half
    typedef struct packed {
        logic [4:0] crc5;
        logic [3:0] endp;
        logic [6:0] addr;
    } TokenPacket;

    // PID plus two token bytes
    localparam int TOKEN_LEN = 3;

    // ==================================================================
    // Byte events on the packet path
    // ==================================================================

    // One receiver event
    // data is the payload byte on byteStrobe, else the packet PID
    typedef struct packed {
        logic       byteStrobe;
        logic [7:0] data;
        logic       endStrobe;
        logic       ok;
        PacketKind  kind;
        TokenPacket token;
    } RxEvent;

    // One byte toward the transmitter
    typedef struct packed {
        logic       valid;
        logic       last;
        logic [7:0] data;
    } TxByte;

endpackage

/* design/usbEpPkg.sv */
package usbEpPkg;

    // ==================================================================
    // Endpoint organisation
    // ==================================================================

    // Data endpoints 1 to NUM_EPS
    localparam int NUM_EPS = 3;

    // Bytes per receive buffer or transmit queue
    localparam int EP_DEPTH = 16;

    // Index bits into one buffer
    localparam int EP_PTR_W = $clog2(EP_DEPTH);

    // Buffer pointer, top bit tells full from empty
    typedef logic [EP_PTR_W:0] EpPtr;

    // Endpoint number as latched from a token
    typedef logic [1:0] EpId;

    // One bit per endpoint, bit 0 is endpoint 1
    typedef logic [NUM_EPS-1:0] EpMask;

    // Head bytes of all receive buffers
    typedef logic [NUM_EPS-1:0][7:0] EpBytes;

    // One application push into a transmit queue
    typedef struct packed {
        logic       valid;
        logic       last;
        logic [7:0] data;
    } EpFill;

    typedef EpFill [NUM_EPS-1:0] EpFillVec;

endpackage

/* design/packetReceiver.sv */
module packetReceiver (
    input  logic                 clk48_i,
    input  logic                 rst_i,
    input  logic                 rxDataValid_i,
    input  logic [7:0]           rxData_i,
    input  logic                 rxIsLastByte_i,
    input  logic                 keepPacket_i,
    input  logic                 sendingPhase_i,
    output logic                 rxAcceptNewData_o,
    output usbPacketPkg::RxEvent rxEvent_o
);

    import usbPacketPkg::*;

    // Byte index in the packet, sticks at 3
    logic [1:0] byteIdx;
    logic [7:0] pidReg;
    logic [7:0] curPid;
    PacketKind  curKind;
    logic       take;
    logic       isPayload;
    logic       lenOk;

    // Event registers
    logic       byteStrobeReg;
    logic       endStrobeReg;
    logic [7:0] dataReg;
    logic       okReg;
    PacketKind  kindReg;
    TokenPacket tokenReg;

    // Receive side closed while a reply goes out
    assign rxAcceptNewData_o = !sendingPhase_i;
    assign take = rxDataValid_i && rxAcceptNewData_o;

    // PID of the packet in flight, first byte included
    assign curPid = (byteIdx == 2'd0) ? rxData_i : pidReg;

    always_comb begin
        case (curPid)
            pidOut, pidIn, pidSetup: curKind = kindToken;
            pidData0, pidData1:      curKind = kindData;
            default:                 curKind = kindOther;
        endcase
    end

    // Everything after a data PID is payload
    assign isPayload = (curKind == kindData) && (byteIdx != 2'd0);

    // Tokens must end exactly on their last byte
    assign lenOk = (curKind != kindToken) || (byteIdx == 2'(TOKEN_LEN - 1));

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            byteIdx <= 2'd0;
            byteStrobeReg <= 1'b0;
            endStrobeReg <= 1'b0;
        end else begin
            byteStrobeReg <= take && isPayload;
            endStrobeReg <= take && rxIsLastByte_i;
            if (take) begin
                if (rxIsLastByte_i) begin
                    byteIdx <= 2'd0;
                end else if (byteIdx != 2'd3) begin
                    byteIdx <= byteIdx + 2'd1;
                end
            end
        end
    end

    // PID, token bytes and event payload
    always_ff @(posedge clk48_i) begin
        if (take) begin
            dataReg <= isPayload ? rxData_i : curPid;
            okReg <= keepPacket_i && lenOk;
            kindReg <= curKind;
            if (byteIdx == 2'd0) begin
                pidReg <= rxData_i;
            end
            if (byteIdx == 2'd1) begin
                tokenReg[7:0] <= rxData_i;
            end
            if (byteIdx == 2'd2) begin
                tokenReg[15:8] <= rxData_i;
            end
        end
    end

    assign rxEvent_o = '{byteStrobe: byteStrobeReg, data: dataReg, endStrobe: endStrobeReg,
                         ok: okReg, kind: kindReg, token: tokenReg};

endmodule

/* design/transactionFsm.sv */
module transactionFsm (
    input  logic                 clk48_i,
    input  logic                 rst_i,
    input  usbPacketPkg::RxEvent rxEvent_i,
    input  logic                 rxCommitted_i,
    input  logic                 txReady_i,
    input  usbPacketPkg::TxByte  txHead_i,
    input  logic                 txAcceptNewData_i,
    output usbEpPkg::EpId        epSel_o,
    output logic                 rxWrite_o,
    output logic                 rxEnd_o,
    output logic                 rxOk_o,
    output logic                 txPop_o,
    output logic                 isSendingPhase_o,
    output usbPacketPkg::TxByte  tx_o
);

    import usbPacketPkg::*;
    import usbEpPkg::*;

    typedef enum logic [2:0] {
        waitToken,
        awaitData,
        checkCommit,
        sendAck,
        sendPid,
        sendPayload,
        sendNak
    } TransState;

    TransState state;
    TxByte     txReg;
    logic      tokenEnd;
    logic      epInRange;
    logic      isOutOrIn;
    logic      txTaken;

    // ==================================================================
    // Token decode
    // ==================================================================

    assign tokenEnd = rxEvent_i.endStrobe && rxEvent_i.ok && (rxEvent_i.kind == kindToken);

    // Endpoint 0 and anything above NUM_EPS are dropped
    assign epInRange = (rxEvent_i.token.endp != 4'd0)
                    && (rxEvent_i.token.endp <= 4'(NUM_EPS));

    // PID rides in data when no payload byte is strobed
    assign isOutOrIn = (rxEvent_i.data == pidOut) || (rxEvent_i.data == pidIn);

    // ==================================================================
    // Endpoint and transmit strobes
    // ==================================================================

    assign txTaken = tx_o.valid && txAcceptNewData_i;

    // Buffer writes only while the data packet is expected
    assign rxWrite_o = (state == awaitData) && rxEvent_i.byteStrobe;
    assign rxEnd_o = (state == awaitData) && rxEvent_i.endStrobe
                  && (rxEvent_i.kind == kindData);
    assign rxOk_o = rxEvent_i.ok;

    // One pop per payload byte taken
    assign txPop_o = (state == sendPayload) && txTaken;

    assign isSendingPhase_o = (state == sendAck) || (state == sendPid)
                           || (state == sendPayload) || (state == sendNak);

    // Payload comes straight from the queue head
    assign tx_o = (state == sendPayload) ? txHead_i : txReg;

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            state <= waitToken;
            epSel_o <= '0;
            txReg <= '0;
        end else begin
            case (state)
                waitToken: begin
                    if (tokenEnd && epInRange && isOutOrIn) begin
                        epSel_o <= EpId'(rxEvent_i.token.endp);
                        state <= (rxEvent_i.data == pidIn) ? sendPid : awaitData;
                    end
                end
                awaitData: begin
                    // Anything but a data packet aborts
                    if (rxEvent_i.endStrobe) begin
                        state <= (rxEvent_i.kind == kindData) ? checkCommit : waitToken;
                    end
                end
                checkCommit: begin
                    // Failed packets get no reply
                    if (rxCommitted_i) begin
                        txReg <= '{valid: 1'b1, last: 1'b1, data: pidAck};
                        state <= sendAck;
                    end else begin
                        state <= waitToken;
                    end
                end
                sendPid: begin
                    // First cycle picks DATA0 or NAK
                    if (!txReg.valid) begin
                        if (txReady_i) begin
                            txReg <= '{valid: 1'b1, last: 1'b0, data: pidData0};
                        end else begin
                            txReg <= '{valid: 1'b1, last: 1'b1, data: pidNak};
                            state <= sendNak;
                        end
                    end else if (txTaken) begin
                        txReg.valid <= 1'b0;
                        state <= sendPayload;
                    end
                end
                sendPayload: begin
                    if (txTaken && txHead_i.last) begin
                        state <= waitToken;
                    end
                end
                sendAck, sendNak: begin
                    if (txTaken) begin
                        txReg.valid <= 1'b0;
                        state <= waitToken;
                    end
                end
                default: state <= waitToken;
            endcase
        end
    end

endmodule

/* design/rxEndpointBuffer.sv */
module rxEndpointBuffer (
    input  logic       clk48_i,
    input  logic       rst_i,
    input  logic       wrEn_i,
    input  logic [7:0] wrData_i,
    input  logic       endEn_i,
    input  logic       endOk_i,
    input  logic       pop_i,
    output logic       committed_o,
    output logic       avail_o,
    output logic [7:0] data_o
);

    import usbEpPkg::*;

    logic [7:0] mem [EP_DEPTH];

    // Host reads up to commitPtr, the packet being received runs ahead in wrPtr
    EpPtr rdPtr;
    EpPtr commitPtr;
    EpPtr wrPtr;
    EpPtr wrPtrNext;
    logic overflow;
    logic full;
    logic doWrite;
    logic commitOk;

    assign full = (wrPtr - rdPtr) == EpPtr'(EP_DEPTH);
    assign doWrite = wrEn_i && !full;
    assign wrPtrNext = doWrite ? wrPtr + EpPtr'(1) : wrPtr;

    // Last byte may itself overflow
    assign commitOk = endOk_i && !overflow && !(wrEn_i && full);

    // Only committed bytes are visible
    assign avail_o = commitPtr != rdPtr;
    assign data_o = mem[rdPtr[EP_PTR_W-1:0]];

    always_ff @(posedge clk48_i) begin
        if (doWrite) begin
            mem[wrPtr[EP_PTR_W-1:0]] <= wrData_i;
        end
    end

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            rdPtr <= '0;
            commitPtr <= '0;
            wrPtr <= '0;
            overflow <= 1'b0;
            committed_o <= 1'b0;
        end else begin
            committed_o <= endEn_i && commitOk;
            if (pop_i && avail_o) begin
                rdPtr <= rdPtr + EpPtr'(1);
            end
            if (endEn_i) begin
                overflow <= 1'b0;
                if (commitOk) begin
                    commitPtr <= wrPtrNext;
                    wrPtr <= wrPtrNext;
                end else begin
                    // Rollback drops the whole packet
                    wrPtr <= commitPtr;
                end
            end else begin
                wrPtr <= wrPtrNext;
                if (wrEn_i && full) begin
                    overflow <= 1'b1;
                end
            end
        end
    end

endmodule

/* design/txEndpointQueue.sv */
module txEndpointQueue (
    input  logic                clk48_i,
    input  logic                rst_i,
    input  usbEpPkg::EpFill     fill_i,
    input  logic                pop_i,
    output logic                full_o,
    output logic                ready_o,
    output usbPacketPkg::TxByte head_o
);

    import usbEpPkg::*;

    // Entry is the last flag over the data byte
    logic [8:0] mem [EP_DEPTH];
    EpPtr       wrPtr;
    EpPtr       rdPtr;

    // Complete packets waiting
    EpPtr       pktCount;
    logic       empty;
    logic       push;
    logic       pull;
    logic [8:0] headEntry;

    assign empty = wrPtr == rdPtr;
    assign full_o = (wrPtr - rdPtr) == EpPtr'(EP_DEPTH);
    assign push = fill_i.valid && !full_o;
    assign pull = pop_i && !empty;
    assign ready_o = pktCount != '0;

    assign headEntry = mem[rdPtr[EP_PTR_W-1:0]];
    assign head_o = '{valid: !empty, last: headEntry[8], data: headEntry[7:0]};

    always_ff @(posedge clk48_i) begin
        if (push) begin
            mem[wrPtr[EP_PTR_W-1:0]] <= {fill_i.last, fill_i.data};
        end
    end

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            wrPtr <= '0;
            rdPtr <= '0;
            pktCount <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + EpPtr'(1);
            end
            if (pull) begin
                rdPtr <= rdPtr + EpPtr'(1);
            end
            // Packet enters on its last push, leaves on its last pop
            case ({push && fill_i.last, pull && headEntry[8]})
                2'b10:   pktCount <= pktCount + EpPtr'(1);
                2'b01:   pktCount <= pktCount - EpPtr'(1);
                default: pktCount <= pktCount;
            endcase
        end
    end

endmodule

/* design/endpointBank.sv */
module endpointBank (
    input  logic                clk48_i,
    input  logic                rst_i,
    input  usbEpPkg::EpId       epSel_i,
    input  logic                rxWrite_i,
    input  logic [7:0]          rxData_i,
    input  logic                rxEnd_i,
    input  logic                rxOk_i,
    input  logic                txPop_i,
    input  usbEpPkg::EpMask     hostPop_i,
    input  usbEpPkg::EpFillVec  devFill_i,
    output logic                rxCommitted_o,
    output logic                txReady_o,
    output usbPacketPkg::TxByte txHead_o,
    output usbEpPkg::EpMask     hostAvail_o,
    output usbEpPkg::EpBytes    hostData_o,
    output usbEpPkg::EpMask     devFull_o
);

    import usbPacketPkg::*;
    import usbEpPkg::*;

    // One-hot select, bit i is endpoint i+1
    EpMask epHit;
    EpMask committed;
    EpMask ready;
    TxByte heads [NUM_EPS];

    // ==================================================================
    // Per-endpoint buffers
    // ==================================================================

    for (genvar i = 0; i < NUM_EPS; i++) begin : genEp
        rxEndpointBuffer rxBuf (
            .clk48_i     (clk48_i),
            .rst_i       (rst_i),
            .wrEn_i      (rxWrite_i && epHit[i]),
            .wrData_i    (rxData_i),
            .endEn_i     (rxEnd_i && epHit[i]),
            .endOk_i     (rxOk_i),
            .pop_i       (hostPop_i[i]),
            .committed_o (committed[i]),
            .avail_o     (hostAvail_o[i]),
            .data_o      (hostData_o[i])
        );

        txEndpointQueue txQueue (
            .clk48_i (clk48_i),
            .rst_i   (rst_i),
            .fill_i  (devFill_i[i]),
            .pop_i   (txPop_i && epHit[i]),
            .full_o  (devFull_o[i]),
            .ready_o (ready[i]),
            .head_o  (heads[i])
        );
    end

    // ==================================================================
    // Return path to the FSM
    // ==================================================================

    always_comb begin
        txHead_o = '0;
        for (int i = 0; i < NUM_EPS; i++) begin
            epHit[i] = epSel_i == EpId'(i + 1);
            if (epHit[i]) begin
                txHead_o = heads[i];
            end
        end
    end

    assign rxCommitted_o = |(committed & epHit);
    assign txReady_o = |(ready & epHit);

endmodule

/* design/usbPe.sv */
module usbPe (
    input  logic                clk48_i,
    input  logic                rst_i,
    output logic                isSendingPhase_o,
    // Receive strobes
    output logic                rxAcceptNewData_o,
    input  logic [7:0]          rxData_i,
    input  logic                rxIsLastByte_i,
    input  logic                rxDataValid_i,
    input  logic                keepPacket_i,
    // Transmit strobes
    output logic                txDataValid_o,
    output logic                txIsLastByte_o,
    output logic [7:0]          txData_o,
    input  logic                txAcceptNewData_i,
    // Application side, index 0 is endpoint 1
    input  usbEpPkg::EpMask     hostPop_i,
    output usbEpPkg::EpMask     hostAvail_o,
    output usbEpPkg::EpBytes    hostData_o,
    input  usbEpPkg::EpFillVec  devFill_i,
    output usbEpPkg::EpMask     devFull_o
);

    import usbPacketPkg::*;
    import usbEpPkg::*;

    RxEvent rxEvent;
    TxByte  tx;
    TxByte  txHead;
    EpId    epSel;
    logic   rxWrite;
    logic   rxEnd;
    logic   rxOk;
    logic   rxCommitted;
    logic   txReady;
    logic   txPop;

    assign txDataValid_o = tx.valid;
    assign txIsLastByte_o = tx.last;
    assign txData_o = tx.data;

    packetReceiver receiver (
        .clk48_i           (clk48_i),
        .rst_i             (rst_i),
        .rxDataValid_i     (rxDataValid_i),
        .rxData_i          (rxData_i),
        .rxIsLastByte_i    (rxIsLastByte_i),
        .keepPacket_i      (keepPacket_i),
        .sendingPhase_i    (isSendingPhase_o),
        .rxAcceptNewData_o (rxAcceptNewData_o),
        .rxEvent_o         (rxEvent)
    );

    transactionFsm fsm (
        .clk48_i           (clk48_i),
        .rst_i             (rst_i),
        .rxEvent_i         (rxEvent),
        .rxCommitted_i     (rxCommitted),
        .txReady_i         (txReady),
        .txHead_i          (txHead),
        .txAcceptNewData_i (txAcceptNewData_i),
        .epSel_o           (epSel),
        .rxWrite_o         (rxWrite),
        .rxEnd_o           (rxEnd),
        .rxOk_o            (rxOk),
        .txPop_o           (txPop),
        .isSendingPhase_o  (isSendingPhase_o),
        .tx_o              (tx)
    );

    endpointBank bank (
        .clk48_i       (clk48_i),
        .rst_i         (rst_i),
        .epSel_i       (epSel),
        .rxWrite_i     (rxWrite),
        .rxData_i      (rxEvent.data),
        .rxEnd_i       (rxEnd),
        .rxOk_i        (rxOk),
        .txPop_i       (txPop),
        .hostPop_i     (hostPop_i),
        .devFill_i     (devFill_i),
        .rxCommitted_o (rxCommitted),
        .txReady_o     (txReady),
        .txHead_o      (txHead),
        .hostAvail_o   (hostAvail_o),
        .hostData_o    (hostData_o),
        .devFull_o     (devFull_o)
    );

endmodule

/* tb/usbPe_props.sv */
module usbPeProps (
    input logic       clk48_i,
    input logic       rst_i,
    input logic       rxAccept_i,
    input logic       txValid_i,
    input logic       txLast_i,
    input logic [7:0] txData_i,
    input logic       txAccept_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // ==================================================================
    // Transmit port rules
    // ==================================================================

    // Quiet line once reset has been seen
    txIdleAfterReset: assert property (@(posedge clk48_i) $past(rst_i) |-> !txValid_i)
        else $error("transmit byte valid in the cycle after reset");

    // Receive side closed during a reply
    rxClosedWhileSending: assert property (@(posedge clk48_i) disable iff (rst_i)
        txValid_i |-> !rxAccept_i)
        else $error("receive side open while a transmit byte is valid");

    // Stalled byte holds still
    txStableUnderStall: assert property (@(posedge clk48_i) disable iff (rst_i)
        (txValid_i && !txAccept_i) |=> (txValid_i && $stable({txLast_i, txData_i})))
        else $error("transmit byte changed before it was accepted");

endmodule

bind usbPe usbPeProps props (
    .clk48_i    (clk48_i),
    .rst_i      (rst_i),
    .rxAccept_i (rxAcceptNewData_o),
    .txValid_i  (txDataValid_o),
    .txLast_i   (txIsLastByte_o),
    .txData_i   (txData_o),
    .txAccept_i (txAcceptNewData_i)
);

/* tb/usbPeTb.sv */
module usbPeTb;

    timeunit 1ns;
    timeprecision 100ps;

    import usbPacketPkg::*;
    import usbEpPkg::*;

    // 120 transactions of at most about 300 cycles each
    localparam int NUM_TRANS = 120;
    localparam int CYCLE_LIMIT = NUM_TRANS * 300 + 4000;

    logic       clk48_i;
    logic       rst_i;
    logic       isSendingPhase_o;
    logic       rxAcceptNewData_o;
    logic [7:0] rxData_i;
    logic       rxIsLastByte_i;
    logic       rxDataValid_i;
    logic       keepPacket_i;
    logic       txDataValid_o;
    logic       txIsLastByte_o;
    logic [7:0] txData_o;
    logic       txAcceptNewData_i;
    EpMask      hostPop_i;
    EpMask      hostAvail_o;
    EpBytes     hostData_o;
    EpFillVec   devFill_i;
    EpMask      devFull_o;

    // Committed host bytes and queued device entries per endpoint
    logic [7:0] rxModel [NUM_EPS][$];
    logic [8:0] txModel [NUM_EPS][$];
    // Expected and observed transmit bytes, last flag on top
    logic [8:0] txExp [$];
    logic [8:0] txSeen [$];
    logic [7:0] payload [$];
    int         cycles = 0;

    usbPe DUT (.*);

    // ==================================================================
    // Clock, back-pressure, monitor, timeout
    // ==================================================================

    initial begin
        clk48_i = 1'b0;
        forever #2 clk48_i = ~clk48_i;
    end

    // Transmit side stalls about one cycle in three
    initial begin
        txAcceptNewData_i = 1'b0;
        forever begin
            @(posedge clk48_i);
            #1;
            txAcceptNewData_i = ($urandom % 3) != 0;
        end
    end

    // Sampled mid-cycle where all strobes have settled
    always @(negedge clk48_i) begin
        if (!rst_i) begin
            // Receive side stays closed while a reply byte is on the wire
            if (txDataValid_o) begin
                checkValue("isSendingPhase_o", 32'(isSendingPhase_o), 32'h1);
                checkValue("rxAcceptNewData_o", 32'(rxAcceptNewData_o), 32'h0);
            end
            if (txDataValid_o && txAcceptNewData_i) begin
                txSeen.push_back({txIsLastByte_o, txData_o});
            end
        end
    end

    always @(posedge clk48_i) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // ==================================================================
    // Helpers
    // ==================================================================

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %s got 0x%h expected 0x%h", name, got, exp);
            $display("** FAIL **");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // To the drive point of the next cycle
    task automatic stepCycle();
        @(posedge clk48_i);
        #1;
    endtask

    // Byte held until the receiver accepts it
    task automatic sendByte(input logic [7:0] data, input logic last, input logic keep);
        logic taken;
        rxDataValid_i = 1'b1;
        rxData_i = data;
        rxIsLastByte_i = last;
        keepPacket_i = keep;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk48_i);
            taken = rxAcceptNewData_o;
            stepCycle();
        end
        rxDataValid_i = 1'b0;
        rxIsLastByte_i = 1'b0;
    endtask

    // Byte 1 is endp[0] over addr and byte 2 is crc5 over endp[3:1]
    task automatic sendToken(input logic [7:0] pid, input logic [3:0] endp, input int len);
        logic [7:0] bytes [4];
        bytes[0] = pid;
        bytes[1] = {endp[0], 7'($urandom)};
        bytes[2] = {5'($urandom), endp[3:1]};
        bytes[3] = 8'($urandom);
        for (int i = 0; i < len; i++) begin
            sendByte(bytes[i], i == len - 1, 1'b1);
        end
    endtask

    task automatic sendData(input logic [7:0] pid, input logic keep);
        sendByte(pid, 1'b0, keep);
        for (int i = 0; i < payload.size(); i++) begin
            sendByte(payload[i], i == payload.size() - 1, keep);
        end
    endtask

    // Reply against the model and nothing more on the wire after it
    task automatic checkReply();
        if (txExp.size() == 0) begin
            repeat (8) stepCycle();
        end else begin
            while (txSeen.size() < txExp.size()) begin
                stepCycle();
            end
            stepCycle();
        end
        checkValue("transmit byte count", 32'(txSeen.size()), 32'(txExp.size()));
        for (int i = 0; i < txExp.size(); i++) begin
            checkValue("txIsLastByte_o", 32'(txSeen[i][8]), 32'(txExp[i][8]));
            checkValue("txData_o", 32'(txSeen[i][7:0]), 32'(txExp[i][7:0]));
        end
        checkValue("isSendingPhase_o", 32'(isSendingPhase_o), 32'h0);
        checkValue("rxAcceptNewData_o", 32'(rxAcceptNewData_o), 32'h1);
        txSeen.delete();
        txExp.delete();
    endtask

    // Empty every host buffer byte by byte against the model
    task automatic drainHost();
        logic more;
        for (int ep = 0; ep < NUM_EPS; ep++) begin
            more = 1'b1;
            hostPop_i[ep] = 1'b1;
            while (more) begin
                @(negedge clk48_i);
                checkValue("hostAvail_o", 32'(hostAvail_o[ep]), 32'(rxModel[ep].size() != 0));
                more = hostAvail_o[ep];
                if (more) begin
                    checkValue("hostData_o", 32'(hostData_o[ep]), 32'(rxModel[ep].pop_front()));
                end
                stepCycle();
            end
            hostPop_i[ep] = 1'b0;
        end
    endtask

    task automatic fillPacket(input int ep, input int len);
        for (int i = 0; i < len; i++) begin
            checkValue("devFull_o", 32'(devFull_o[ep]), 32'(txModel[ep].size() >= EP_DEPTH));
            devFill_i[ep] = '{valid: 1'b1, last: i == len - 1, data: 8'($urandom)};
            txModel[ep].push_back({devFill_i[ep].last, devFill_i[ep].data});
            stepCycle();
        end
        devFill_i[ep] = '0;
    endtask

    // ==================================================================
    // Transactions
    // ==================================================================

    task automatic runOut(input int ep);
        int         len;
        logic       keep;
        logic [7:0] pid;
        drainHost();
        // Lengths past EP_DEPTH overflow and roll back
        len = 1 + int'($urandom % 20);
        keep = ($urandom % 6) != 0;
        pid = (($urandom % 2) != 0) ? pidData1 : pidData0;
        payload.delete();
        for (int i = 0; i < len; i++) begin
            payload.push_back(8'($urandom));
        end
        sendToken(pidOut, 4'(ep + 1), TOKEN_LEN);
        sendData(pid, keep);
        if (keep && len <= EP_DEPTH) begin
            for (int i = 0; i < len; i++) begin
                rxModel[ep].push_back(payload[i]);
            end
            txExp.push_back({1'b1, pidAck});
        end
        checkReply();
    endtask

    task automatic runIn(input int ep);
        int         len;
        logic [8:0] entry;
        // Up to two new packets if they fit
        repeat (2) begin
            len = 1 + int'($urandom % EP_DEPTH);
            if (($urandom % 3) != 0 && txModel[ep].size() + len <= EP_DEPTH) begin
                fillPacket(ep, len);
            end
        end
        sendToken(pidIn, 4'(ep + 1), TOKEN_LEN);
        // Model holds whole packets only
        if (txModel[ep].size() == 0) begin
            txExp.push_back({1'b1, pidNak});
        end else begin
            txExp.push_back({1'b0, pidData0});
            do begin
                entry = txModel[ep].pop_front();
                txExp.push_back(entry);
            end while (!entry[8]);
        end
        checkReply();
    endtask

    // Silent cases of bad endpoint, bad length or foreign PID
    task automatic runJunk(input int ep);
        logic [3:0] badEp;
        case ($urandom % 3)
            0: begin
                badEp = (($urandom % 2) != 0) ? 4'd0 : 4'(4 + $urandom % 12);
                sendToken((($urandom % 2) != 0) ? pidOut : pidIn, badEp, TOKEN_LEN);
            end
            1: sendToken(pidOut, 4'(ep + 1), 2 + 2 * int'($urandom % 2));
            default: begin
                case ($urandom % 4)
                    0: sendToken(pidSetup, 4'(ep + 1), TOKEN_LEN);
                    1: sendToken(pidAck, 4'(ep + 1), TOKEN_LEN);
                    2: sendToken(pidStall, 4'(ep + 1), TOKEN_LEN);
                    default: sendToken(pidData1, 4'(ep + 1), TOKEN_LEN);
                endcase
            end
        endcase
        checkReply();
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================

    initial begin
        int ep;
        int pick;
        void'($urandom(32'h89377d7a));
        rst_i = 1'b1;
        rxDataValid_i = 1'b0;
        rxData_i = 8'h00;
        rxIsLastByte_i = 1'b0;
        keepPacket_i = 1'b0;
        hostPop_i = '0;
        devFill_i = '0;
        repeat (16) @(posedge clk48_i);
        #1;
        rst_i = 1'b0;
        // Idle state straight out of reset
        checkValue("rxAcceptNewData_o", 32'(rxAcceptNewData_o), 32'h1);
        checkValue("isSendingPhase_o", 32'(isSendingPhase_o), 32'h0);
        checkValue("txDataValid_o", 32'(txDataValid_o), 32'h0);
        checkValue("hostAvail_o", 32'(hostAvail_o), 32'h0);
        checkValue("devFull_o", 32'(devFull_o), 32'h0);
        for (int t = 0; t < NUM_TRANS; t++) begin
            ep = int'($urandom % NUM_EPS);
            pick = int'($urandom % 8);
            if (pick < 3) begin
                runOut(ep);
            end else if (pick < 6) begin
                runIn(ep);
            end else begin
                runJunk(ep);
            end
        end
        drainHost();
        $display("** PASS **");
        $finish;
    end

endmodule

/* usbPe.f */
design/usbPacketPkg.sv
design/usbEpPkg.sv
design/packetReceiver.sv
design/transactionFsm.sv
design/rxEndpointBuffer.sv
design/txEndpointQueue.sv
design/endpointBank.sv
design/usbPe.sv
tb/usbPe_props.sv
tb/usbPeTb.sv

/* runSim.sh */
#!/bin/sh
# Build and run the usbPe testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module usbPeTb \
    -Mdir obj_dir -o usbPeSim \
    -f usbPe.f
# Nonzero exit on any failing check
./obj_dir/usbPeSim
